// ==== hw/core_cfg_pkg.sv ====
// --------------------
// core datapath widths, fixed for RV32I
// seq_num wraps at 256, so keep fewer ops in flight than that
// --------------------
package core_cfg_pkg;

  // widths ------------
  localparam int p_addr_bits     = 32; // pc
  localparam int p_data_bits     = 32; // operands and results
  localparam int p_seq_num_bits  = 8;  // issue order tag
  localparam int p_reg_addr_bits = 5;  // x0..x31

  // x0 is hardwired to zero, writes to it are dropped
  localparam logic [p_reg_addr_bits-1:0] p_zero_reg = '0;

endpackage

// ==== hw/isa_pkg.sv ====
// --------------------
// micro-ops seen by the execute stage
// only the low half of a multiply is supported, no division
// --------------------
package isa_pkg;

  // register-register ops plus mul
  typedef enum logic [3:0] {
    OP_ADD, OP_SUB,
    OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA,
    OP_SLT, OP_SLTU,
    OP_MUL
  } rv_uop;

  localparam int p_mul_cycles = 32; // one multiplier bit per cycle

  // true when the op belongs to the iterative multiplier
  function automatic logic uop_is_mul(input rv_uop uop);
    return (uop == OP_MUL);
  endfunction

endpackage

// ==== hw/d_x_intf.sv ====
// --------------------
// decode to execute link, valid/ready
// sender holds the payload stable while val is high
// --------------------
`timescale 1ns/1ps

interface d_x_intf
  import core_cfg_pkg::*, isa_pkg::*;
();

  logic                       val;     // op present
  logic                       rdy;     // execute can take it
  logic [p_addr_bits-1:0]     pc;
  logic [p_seq_num_bits-1:0]  seq_num; // issue order
  logic [p_data_bits-1:0]     op1;
  logic [p_data_bits-1:0]     op2;
  logic [p_reg_addr_bits-1:0] waddr;   // destination register
  rv_uop                      uop;

  // decode side, or dispatch toward a unit
  modport sender (
    output val, pc, seq_num, op1, op2, waddr, uop,
    input  rdy
  );

  // receiving execute block
  modport x_intf (
    input  val, pc, seq_num, op1, op2, waddr, uop,
    output rdy
  );

endinterface

// ==== hw/x_w_intf.sv ====
// --------------------
// execute to writeback link, valid/ready
// a unit holds its result stable until the transfer
// --------------------
`timescale 1ns/1ps

interface x_w_intf
  import core_cfg_pkg::*;
();

  logic                       val;     // result present
  logic                       rdy;     // writeback takes it this edge
  logic [p_addr_bits-1:0]     pc;
  logic [p_seq_num_bits-1:0]  seq_num; // reorder key downstream
  logic [p_reg_addr_bits-1:0] waddr;
  logic [p_data_bits-1:0]     wdata;

  // execute unit side
  modport x_intf (
    output val, pc, seq_num, waddr, wdata,
    input  rdy
  );

  // writeback side
  modport w_intf (
    input  val, pc, seq_num, waddr, wdata,
    output rdy
  );

endinterface

// ==== hw/execute_dispatch.sv ====
// --------------------
// steers decoded ops to the alu or the multiplier
// an op for a busy unit stalls decode even if the other is idle
// --------------------
`timescale 1ns/1ps

module execute_dispatch
  import isa_pkg::*;
(
  d_x_intf.x_intf D,     // from decode
  d_x_intf.sender alu_d, // toward the alu
  d_x_intf.sender mul_d  // toward the multiplier
);

  logic to_mul; // op class from the uop

  assign to_mul = uop_is_mul(D.uop);

  // valid only toward the chosen unit ------
  assign alu_d.val = D.val & ~to_mul;
  assign mul_d.val = D.val & to_mul;

  // payload fans out to both and only one sees val
  assign alu_d.pc      = D.pc;
  assign alu_d.seq_num = D.seq_num;
  assign alu_d.op1     = D.op1;
  assign alu_d.op2     = D.op2;
  assign alu_d.waddr   = D.waddr;
  assign alu_d.uop     = D.uop;

  assign mul_d.pc      = D.pc;
  assign mul_d.seq_num = D.seq_num;
  assign mul_d.op1     = D.op1;
  assign mul_d.op2     = D.op2;
  assign mul_d.waddr   = D.waddr;
  assign mul_d.uop     = D.uop;

  // ready of the selected unit goes back to decode
  assign D.rdy = to_mul ? mul_d.rdy : alu_d.rdy;

  // undefined encodings would fall through to the alu and return zero
  a_legal_uop: assert final (!D.val || D.uop <= OP_MUL)
    else $error("dispatch saw an undefined uop encoding");

endmodule

// ==== hw/alu.sv ====
// --------------------
// single-entry alu for RV32I register-register ops
// result shows the cycle after accept, one op per cycle with no back-pressure
// --------------------
`timescale 1ns/1ps

module alu
  import core_cfg_pkg::*, isa_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  d_x_intf.x_intf D, // ops from dispatch
  x_w_intf.x_intf W  // results to the arbiter
);

  // input register --------------------
  logic                       val_q;     // entry occupied
  logic [p_addr_bits-1:0]     pc_q;
  logic [p_seq_num_bits-1:0]  seq_num_q;
  logic [p_data_bits-1:0]     op1_q;
  logic [p_data_bits-1:0]     op2_q;
  logic [p_reg_addr_bits-1:0] waddr_q;
  rv_uop                      uop_q;

  logic d_xfer;
  logic w_xfer;
  logic [4:0] shamt; // rs2[4:0] per RV32I

  assign d_xfer = D.val & D.rdy;
  assign w_xfer = W.val & W.rdy;

  always_ff @(posedge clk) begin
    if (rst)
      val_q <= 1'b0;
    else if (d_xfer)
      val_q <= 1'b1; // new op, may replace one leaving now
    else if (w_xfer)
      val_q <= 1'b0; // drained
  end

  // payload, loaded on accept only
  always_ff @(posedge clk) begin
    if (d_xfer) begin
      pc_q      <= D.pc;
      seq_num_q <= D.seq_num;
      op1_q     <= D.op1;
      op2_q     <= D.op2;
      waddr_q   <= D.waddr;
      uop_q     <= D.uop;
    end
  end

  // arithmetic --------------------
  assign shamt = op2_q[4:0];

  always_comb begin
    case (uop_q)
      OP_ADD:  W.wdata = op1_q + op2_q;
      OP_SUB:  W.wdata = op1_q - op2_q;
      OP_AND:  W.wdata = op1_q & op2_q;
      OP_OR:   W.wdata = op1_q | op2_q;
      OP_XOR:  W.wdata = op1_q ^ op2_q;
      OP_SLL:  W.wdata = op1_q << shamt;
      OP_SRL:  W.wdata = op1_q >> shamt;
      OP_SRA:  W.wdata = $signed(op1_q) >>> shamt; // sign fill
      OP_SLT:  W.wdata = {{(p_data_bits-1){1'b0}}, $signed(op1_q) < $signed(op2_q)};
      OP_SLTU: W.wdata = {{(p_data_bits-1){1'b0}}, op1_q < op2_q};
      default: W.wdata = '0; // mul never lands here
    endcase
  end

  // handshake and passthrough fields
  assign D.rdy     = W.rdy | ~val_q; // empty, or emptying this edge
  assign W.val     = val_q;
  assign W.pc      = pc_q;
  assign W.seq_num = seq_num_q;
  assign W.waddr   = waddr_q;

  // checks --------------------
  // dispatch keeps multiplies away from here
  a_no_mul: assert property (@(posedge clk) disable iff (rst)
    D.val |-> D.uop != OP_MUL);

  // stalled result stays put until writeback takes it
  a_hold: assert property (@(posedge clk) disable iff (rst)
    W.val && !W.rdy |=> W.val && $stable(W.seq_num) && $stable(W.wdata));

endmodule

// ==== hw/mul_unit.sv ====
// --------------------
// iterative shift-add multiplier, low 32 bits of the product only
// result valid exactly p_mul_cycles after accept, one op at a time
// --------------------
`timescale 1ns/1ps

module mul_unit
  import core_cfg_pkg::*, isa_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  d_x_intf.x_intf D, // multiplies from dispatch
  x_w_intf.x_intf W  // product to the arbiter
);

  localparam int p_cnt_bits = $clog2(p_mul_cycles);

  // state --------------------
  logic [p_cnt_bits-1:0]      cnt_q;     // steps left, zero when not running
  logic                       done_q;    // product held for writeback
  logic [p_data_bits-1:0]     mcand_q;   // multiplicand, shifts left
  logic [p_data_bits-1:0]     mplier_q;  // multiplier, lsb first
  logic [p_data_bits-1:0]     acc_q;     // partial product
  logic [p_addr_bits-1:0]     pc_q;
  logic [p_seq_num_bits-1:0]  seq_num_q;
  logic [p_reg_addr_bits-1:0] waddr_q;

  logic                   d_xfer;
  logic                   w_xfer;
  logic                   busy;
  logic [p_data_bits-1:0] src_mcand;
  logic [p_data_bits-1:0] src_mplier;
  logic [p_data_bits-1:0] src_acc;
  logic [p_data_bits-1:0] acc_next;

  assign d_xfer = D.val & D.rdy;
  assign w_xfer = W.val & W.rdy;
  assign busy   = (cnt_q != '0);

  // step 0 runs on the accept edge, straight from the operands
  always_comb begin
    src_mcand  = d_xfer ? D.op1 : mcand_q;
    src_mplier = d_xfer ? D.op2 : mplier_q;
    src_acc    = d_xfer ? '0 : acc_q;
    acc_next   = src_acc + (src_mplier[0] ? src_mcand : '0);
  end

  // control --------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q  <= '0;
      done_q <= 1'b0;
    end else if (d_xfer) begin
      cnt_q  <= p_cnt_bits'(p_mul_cycles - 1); // remaining steps
      done_q <= 1'b0;
    end else if (busy) begin
      cnt_q  <= cnt_q - 1'b1;
      done_q <= (cnt_q == p_cnt_bits'(1)); // last step
    end else if (w_xfer) begin
      done_q <= 1'b0;
    end
  end

  // datapath, no reset
  always_ff @(posedge clk) begin
    if (d_xfer | busy) begin
      mcand_q  <= src_mcand << 1;
      mplier_q <= src_mplier >> 1;
      acc_q    <= acc_next; // bits past 31 fall off
    end
    if (d_xfer) begin
      pc_q      <= D.pc;
      seq_num_q <= D.seq_num;
      waddr_q   <= D.waddr;
    end
  end

  // idle, or the held product leaves this edge
  assign D.rdy     = ~busy & (~done_q | W.rdy);
  assign W.val     = done_q;
  assign W.pc      = pc_q;
  assign W.seq_num = seq_num_q;
  assign W.waddr   = waddr_q;
  assign W.wdata   = acc_q;

  // checks --------------------
  a_no_val_busy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !W.val);

  // fixed latency from accept to result
  a_latency: assert property (@(posedge clk) disable iff (rst)
    d_xfer |-> ##p_mul_cycles W.val);

endmodule

// ==== hw/writeback_arbiter.sv ====
// --------------------
// round-robin merge of alu and mul results onto one writeback port
// the winner is kept while writeback stalls, w_wen drops for x0
// --------------------
`timescale 1ns/1ps

module writeback_arbiter
  import core_cfg_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  x_w_intf.w_intf                    alu_w,
  x_w_intf.w_intf                    mul_w,
  output logic                       w_val,
  input  logic                       w_rdy,
  output logic [p_addr_bits-1:0]     w_pc,
  output logic [p_seq_num_bits-1:0]  w_seq_num,
  output logic [p_reg_addr_bits-1:0] w_waddr,
  output logic [p_data_bits-1:0]     w_wdata,
  output logic                       w_wen
);

  logic last_mul_q; // last transfer came from the multiplier
  logic hold_q;     // output stalled last cycle
  logic hold_sel_q; // winner during that stall
  logic sel_mul;    // current grant, 1 = multiplier

  // grant --------------------
  always_comb begin
    if (hold_q)
      sel_mul = hold_sel_q; // stalled winner still valid, keep it
    else if (alu_w.val & mul_w.val)
      sel_mul = ~last_mul_q; // both waiting, other one's turn
    else
      sel_mul = mul_w.val;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_mul_q <= 1'b0;
      hold_q     <= 1'b0;
      hold_sel_q <= 1'b0;
    end else begin
      if (w_val & w_rdy)
        last_mul_q <= sel_mul; // pointer moves on transfer only
      hold_q     <= w_val & ~w_rdy;
      hold_sel_q <= sel_mul;
    end
  end

  // output mux
  assign w_val     = alu_w.val | mul_w.val;
  assign w_pc      = sel_mul ? mul_w.pc : alu_w.pc;
  assign w_seq_num = sel_mul ? mul_w.seq_num : alu_w.seq_num;
  assign w_waddr   = sel_mul ? mul_w.waddr : alu_w.waddr;
  assign w_wdata   = sel_mul ? mul_w.wdata : alu_w.wdata;
  assign w_wen     = (w_waddr != p_zero_reg); // x0 writes dropped here only

  // loser sees rdy low
  assign alu_w.rdy = w_rdy & ~sel_mul;
  assign mul_w.rdy = w_rdy & sel_mul;

  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    w_val && !w_rdy |=> w_val && $stable(w_seq_num));

endmodule

// ==== hw/execute_unit.sv ====
// --------------------
// execute stage top, alu plus iterative multiplier
// results leave out of order, reorder downstream by w_seq_num
// --------------------
`timescale 1ns/1ps

module execute_unit
  import core_cfg_pkg::*, isa_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst,
  // decode side
  input  logic                       d_val,
  output logic                       d_rdy,
  input  logic [p_addr_bits-1:0]     d_pc,
  input  logic [p_seq_num_bits-1:0]  d_seq_num,
  input  logic [p_data_bits-1:0]     d_op1,
  input  logic [p_data_bits-1:0]     d_op2,
  input  logic [p_reg_addr_bits-1:0] d_waddr,
  input  rv_uop                      d_uop,
  // writeback side
  output logic                       w_val,
  input  logic                       w_rdy,
  output logic [p_addr_bits-1:0]     w_pc,
  output logic [p_seq_num_bits-1:0]  w_seq_num,
  output logic [p_reg_addr_bits-1:0] w_waddr,
  output logic [p_data_bits-1:0]     w_wdata,
  output logic                       w_wen
);

  d_x_intf d_top (); // decode ports bundled
  d_x_intf d_alu ();
  d_x_intf d_mul ();
  x_w_intf w_alu ();
  x_w_intf w_mul ();

  // plain ports into the decode bundle
  assign d_top.val     = d_val;
  assign d_top.pc      = d_pc;
  assign d_top.seq_num = d_seq_num;
  assign d_top.op1     = d_op1;
  assign d_top.op2     = d_op2;
  assign d_top.waddr   = d_waddr;
  assign d_top.uop     = d_uop;
  assign d_rdy         = d_top.rdy;

  // blocks --------------------
  execute_dispatch u_dispatch (
    .D     (d_top),
    .alu_d (d_alu),
    .mul_d (d_mul)
  );

  alu u_alu (
    .clk (clk),
    .rst (rst),
    .D   (d_alu),
    .W   (w_alu)
  );

  mul_unit u_mul (
    .clk (clk),
    .rst (rst),
    .D   (d_mul),
    .W   (w_mul)
  );

  writeback_arbiter u_arb (
    .clk       (clk),
    .rst       (rst),
    .alu_w     (w_alu),
    .mul_w     (w_mul),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_pc      (w_pc),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata),
    .w_wen     (w_wen)
  );

endmodule

// ==== verification/execute_unit_tb.sv ====
// --------------------
// random ops from a fixed seed and a scoreboard keyed by seq_num
// keeps well under 256 ops in flight so the key never aliases
// --------------------
`timescale 1ns/1ps

module execute_unit_tb
  import core_cfg_pkg::*, isa_pkg::*;
();

  logic clk, rst;
  logic d_val, d_rdy, w_val, w_rdy, w_wen;
  logic [31:0] d_pc, d_op1, d_op2, w_pc, w_wdata;
  logic [7:0] d_seq_num, w_seq_num;
  logic [4:0] d_waddr, w_waddr;
  rv_uop d_uop;

  int seed = 32'h3c433b8b;
  int bp_seed;              // own stream for w_rdy
  int errors, checks, tests, test_base;
  bit timed_out, bp_on;
  int lat_mode;             // 0 none, 1 exact, 2 bounded
  int cyc, outstanding;
  logic [7:0] next_seq;
  logic [31:0] pc_ctr;

  // scoreboard, indexed by seq_num
  bit          exp_valid [256];
  bit          exp_mul   [256];
  logic [31:0] exp_data  [256];
  logic [31:0] exp_pc    [256];
  logic [4:0]  exp_waddr [256];
  int          acc_cyc   [256];

  execute_unit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns
  end

  // reference model --------------------
  function automatic logic [31:0] ref_exec(input rv_uop uop, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0] prod;
    prod = a * b;
    case (uop)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      OP_SRL:  return a >> b[4:0];
      OP_SRA:  return $signed(a) >>> b[4:0];
      OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      default: return prod[31:0]; // low half of mul
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // monitor and scoreboard --------------------
  always @(posedge clk) begin : monitor
    int lat;
    int bound;
    bit prev_stall;
    logic [31:0] prev_pc, prev_wdata;
    logic [7:0] prev_seq;
    logic [4:0] prev_waddr;
    if (!rst) begin
      cyc++;
      if (prev_stall) begin // held output must not move
        check_value("w_val", w_val, 1'b1);
        check_value("w_seq_num", w_seq_num, prev_seq);
        check_value("w_pc", w_pc, prev_pc);
        check_value("w_waddr", w_waddr, prev_waddr);
        check_value("w_wdata", w_wdata, prev_wdata);
      end
      if (d_val && d_rdy) begin
        exp_valid[d_seq_num] = 1'b1;
        exp_mul[d_seq_num]   = uop_is_mul(d_uop);
        exp_data[d_seq_num]  = ref_exec(d_uop, d_op1, d_op2);
        exp_pc[d_seq_num]    = d_pc;
        exp_waddr[d_seq_num] = d_waddr;
        acc_cyc[d_seq_num]   = cyc;
        outstanding++;
      end
      if (w_val && w_rdy) begin
        if (!exp_valid[w_seq_num]) begin
          errors++;
          $display("unexpected or repeated writeback of seq %0d at %0t", w_seq_num, $time);
        end else begin
          check_value("w_wdata", w_wdata, exp_data[w_seq_num]);
          check_value("w_pc", w_pc, exp_pc[w_seq_num]);
          check_value("w_waddr", w_waddr, exp_waddr[w_seq_num]);
          check_value("w_wen", w_wen, exp_waddr[w_seq_num] != 5'd0);
          lat = cyc - acc_cyc[w_seq_num];
          bound = exp_mul[w_seq_num] ? p_mul_cycles : 1;
          if (lat_mode == 1)
            check_value("latency", lat, bound);
          else if (lat_mode == 2 && lat > bound + 1) begin
            errors++; // waited more than one grant
            $display("seq %0d waited %0d cycles, more than one lost grant", w_seq_num, lat);
          end
          exp_valid[w_seq_num] = 1'b0;
          outstanding--;
        end
      end
      prev_stall = w_val && !w_rdy;
      prev_seq   = w_seq_num;
      prev_pc    = w_pc;
      prev_waddr = w_waddr;
      prev_wdata = w_wdata;
    end
  end

  // random back-pressure
  always @(negedge clk) begin
    w_rdy = bp_on ? $random(bp_seed) & 1 : 1'b1;
  end

  // stimulus --------------------
  task automatic issue_op(input rv_uop uop, input logic [31:0] a, input logic [31:0] b,
                          input logic [4:0] rd);
    int waited;
    bit took;
    waited = 0;
    took = 1'b0;
    if (!timed_out) begin
      d_val = 1'b1; // caller sits on a falling edge
      d_uop = uop;
      d_op1 = a;
      d_op2 = b;
      d_waddr = rd;
      d_seq_num = next_seq;
      d_pc = pc_ctr;
      while (!took && !timed_out) begin
        @(posedge clk);
        if (d_rdy) begin
          took = 1'b1;
        end else begin
          waited++;
          if (waited > 100) begin
            timed_out = 1'b1;
            $display("timeout, op with seq %0d was never accepted", next_seq);
          end
        end
        @(negedge clk);
      end
      d_val = 1'b0;
      next_seq++;
      pc_ctr += 4;
    end
  endtask

  task automatic random_op();
    int r;
    r = $random(seed);
    issue_op(rv_uop'($unsigned(r) % 11), $random(seed), $random(seed), $random(seed));
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (outstanding != 0 && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > 2000) begin
        timed_out = 1'b1;
        $display("timeout, %0d results never written back", outstanding);
      end
    end
  endtask

  task automatic test_start();
    test_base = errors;
    tests++;
  endtask

  task automatic test_done(input string name);
    $display("test %0d %s: %0d errors", tests, name, errors - test_base);
  endtask

  // sequence --------------------
  initial begin
    rst = 1'b1;
    d_val = 1'b0;
    d_uop = OP_ADD;
    d_op1 = '0;
    d_op2 = '0;
    d_waddr = '0;
    d_seq_num = '0;
    d_pc = '0;
    w_rdy = 1'b1;
    next_seq = '0;
    pc_ctr = 32'h0000_1000;
    bp_seed = $random(seed);
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_start();
    check_value("d_rdy", d_rdy, 1'b1);
    check_value("w_val", w_val, 1'b0);
    test_done("after reset");

    test_start();
    lat_mode = 1; // one op at a time with exact latency
    issue_op(OP_SLL, 32'h0000_0003, 32'hffff_ffff, 5'd1); // shift by 31
    drain();
    issue_op(OP_SRL, 32'h8000_0001, 32'd31, 5'd2);
    drain();
    issue_op(OP_SRA, 32'h8000_0000, 32'd31, 5'd3);
    drain();
    issue_op(OP_SLT, 32'hffff_fffb, 32'd3, 5'd4); // -5 < 3
    drain();
    issue_op(OP_SLT, 32'd3, 32'hffff_fffb, 5'd5);
    drain();
    issue_op(OP_SLTU, 32'd3, 32'hffff_fffb, 5'd6);
    drain();
    issue_op(OP_SUB, 32'd0, 32'd1, 5'd7);
    drain();
    issue_op(OP_MUL, 32'h8000_0000, 32'hffff_ffff, 5'd8);
    drain();
    issue_op(OP_MUL, 32'h1234_5678, 32'h9abc_def1, 5'd9);
    drain();
    repeat (20) begin
      random_op();
      drain();
    end
    test_done("single ops");

    test_start();
    lat_mode = 0;
    repeat (150) random_op();
    drain();
    test_done("random mix");

    test_start();
    bp_on = 1'b1;
    repeat (150) random_op();
    drain();
    bp_on = 1'b0;
    test_done("back-pressure");

    test_start();
    issue_op(OP_ADD, 32'd5, 32'd6, 5'd0);
    issue_op(OP_ADD, 32'd5, 32'd6, 5'd31);
    issue_op(OP_MUL, 32'd7, 32'd9, 5'd0);
    drain();
    issue_op(OP_MUL, 32'd7, 32'd9, 5'd12);
    drain();
    test_done("x0 destination");

    test_start();
    lat_mode = 2; // mul lands while alu ops stream
    issue_op(OP_MUL, 32'hdead_beef, 32'h0000_0101, 5'd10);
    repeat (45) issue_op(OP_XOR, $random(seed), $random(seed), 5'd11);
    drain();
    lat_mode = 0;
    test_done("round robin");

    $display("summary: %0d tests, %0d checks, %0d errors, timeout %0d",
             tests, checks, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
hw/core_cfg_pkg.sv
hw/isa_pkg.sv
hw/d_x_intf.sv
hw/x_w_intf.sv
hw/execute_dispatch.sv
hw/alu.sv
hw/mul_unit.sv
hw/writeback_arbiter.sv
hw/execute_unit.sv
verification/execute_unit_tb.sv
